//--- queue_states_pkg.sv
/* Queue state store definitions */

`default_nettype none

package queue_states_pkg;

    //////////////////////////////////////////////////
    // Buffer geometry

    localparam int NUM_QUEUES = 8;
    localparam int QUEUE_W = $clog2(NUM_QUEUES);

    localparam int NUM_PAGES = 16;
    localparam int PAGE_W = $clog2(NUM_PAGES);

    localparam int WORDS_PER_PAGE = 8;
    localparam int WORD_W = $clog2(WORDS_PER_PAGE);

    localparam int BYTES_PER_WORD = 8;

    // Byte counters span the whole shared buffer
    localparam int OCC_W = $clog2(NUM_PAGES * WORDS_PER_PAGE * BYTES_PER_WORD);

    // Page lists, one region of NUM_PAGES slots per queue
    localparam int PAGE_LIST_DEPTH = NUM_QUEUES * NUM_PAGES;
    localparam int PAGE_LIST_ADDR_W = $clog2(PAGE_LIST_DEPTH);

    //////////////////////////////////////////////////
    // Pointer channel words

    localparam int TAIL_WORD_W = 1 + PAGE_W + WORD_W;

    // Head lookup word is {head_ptr, page_ptr}
    localparam int HEAD_WORD_W = WORD_W + PAGE_W;

    // Same tail channel word, seen by the writer and by the reader
    typedef union packed {
        struct packed {
            logic              malloc_approved;
            logic [PAGE_W-1:0] next_page_ptr;
            logic [WORD_W-1:0] new_tail_ptr;
        } wr;
        struct packed {
            logic              current_page_valid;
            logic [PAGE_W-1:0] current_page_ptr;
            logic [WORD_W-1:0] tail_ptr;
        } rd;
    } queue_tail_word_u;

endpackage

`default_nettype wire

//--- queue_occupancy.sv
/* Queue byte occupancy */

`timescale 1ns/100ps
`default_nettype none

module queue_occupancy
    import queue_states_pkg::*;
(
    input  wire logic                   enqueue_queue_occupancy_a4l,
    input  wire logic                   reset,

    // Enqueue write and occupancy read
    input  wire logic                   occ_awvalid,
    input  wire logic                   occ_wvalid,
    input  wire logic [QUEUE_W-1:0]     occ_awaddr,
    input  wire logic [OCC_W-1:0]       occ_wdata,
    // Write response is a fixed single-cycle pulse, no hold
    input  wire logic                   occ_bready,
    output var  logic                   occ_bvalid,
    input  wire logic                   occ_arvalid,
    input  wire logic [QUEUE_W-1:0]     occ_araddr,
    input  wire logic                   occ_rready,
    output var  logic                   occ_rvalid,
    output var  logic [OCC_W-1:0]       occ_rdata,

    // Dequeue byte stream
    input  wire logic                   deq_tvalid,
    input  wire logic [OCC_W-1:0]       deq_tdata,
    input  wire logic [QUEUE_W-1:0]     deq_tuser,

    output var  logic [NUM_QUEUES-1:0]  queue_empty
);

    logic [OCC_W-1:0]   occupancy [NUM_QUEUES];
    logic [OCC_W-1:0]   occ_next  [NUM_QUEUES];

    logic               enq_accept;
    logic               collide;

    // Enqueue held back one cycle after a collision
    logic               defer_valid;
    logic [QUEUE_W-1:0] defer_queue;
    logic [OCC_W-1:0]   defer_bytes;

    assign enq_accept = occ_awvalid && occ_wvalid;
    assign collide    = enq_accept && deq_tvalid && (occ_awaddr == deq_tuser);

    //////////////////////////////////////////////////
    // Counter update

    // Enqueue is skipped on collision and added back from the deferral register
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            occ_next[q] = occupancy[q]
                + ((enq_accept && !collide && occ_awaddr == QUEUE_W'(q)) ? occ_wdata : '0)
                + ((defer_valid && defer_queue == QUEUE_W'(q)) ? defer_bytes : '0)
                - ((deq_tvalid && deq_tuser == QUEUE_W'(q)) ? deq_tdata : '0);
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            occupancy   <= '{default: '0};
            occ_bvalid  <= 1'b0;
            defer_valid <= 1'b0;
        end else begin
            occupancy   <= occ_next;
            occ_bvalid  <= enq_accept;
            defer_valid <= collide;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (collide) begin
            defer_queue <= occ_awaddr;
            defer_bytes <= occ_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Occupancy read

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            occ_rvalid <= 1'b0;
        end else if (occ_arvalid) begin
            occ_rvalid <= 1'b1;
        end else if (occ_rready) begin
            occ_rvalid <= 1'b0;
        end
    end

    // Data held while the response waits for rready
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (occ_arvalid) begin
            occ_rdata <= occupancy[occ_araddr];
        end
    end

    // Empty flags straight off the counters
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            queue_empty[q] = ~|occupancy[q];
        end
    end

endmodule

`default_nettype wire

//--- queue_tail_pointers.sv
/* Queue tail pointers and page list append */

`timescale 1ns/100ps
`default_nettype none

module queue_tail_pointers
    import queue_states_pkg::*;
(
    input  wire logic                        enqueue_queue_occupancy_a4l,
    input  wire logic                        reset,

    input  wire logic                        tail_awvalid,
    input  wire logic                        tail_wvalid,
    input  wire logic [QUEUE_W-1:0]          tail_awaddr,
    input  wire logic [TAIL_WORD_W-1:0]      tail_wdata,
    input  wire logic                        tail_bready,
    output var  logic                        tail_bvalid,
    input  wire logic                        tail_arvalid,
    input  wire logic [QUEUE_W-1:0]          tail_araddr,
    input  wire logic                        tail_rready,
    output var  logic                        tail_rvalid,
    output var  logic [TAIL_WORD_W-1:0]      tail_rdata,

    // Page list write and tail read port of the page memory
    output var  logic                        page_wr_en,
    output var  logic [PAGE_LIST_ADDR_W-1:0] page_wr_addr,
    output var  logic [PAGE_W-1:0]           page_wr_data,
    output var  logic [PAGE_LIST_ADDR_W-1:0] tail_rd_addr,
    input  wire logic [PAGE_W-1:0]           tail_rd_page
);

    logic [WORD_W-1:0]     tail_ptrs [NUM_QUEUES];
    logic [PAGE_W-1:0]     wr_slot   [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] list_empty;

    queue_tail_word_u      wr_word;
    queue_tail_word_u      rd_word;
    logic                  wr_accept;
    logic [PAGE_W-1:0]     wr_slot_p1;

    // Read response fields captured at the request
    logic [WORD_W-1:0]     tail_ptr_rd;
    logic                  page_valid_rd;

    assign wr_word    = tail_wdata;
    assign wr_accept  = tail_awvalid && tail_wvalid;
    assign wr_slot_p1 = wr_slot[tail_awaddr] + 1'b1;

    //////////////////////////////////////////////////
    // Tail write and page list append

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            tail_ptrs   <= '{default: '0};
            wr_slot     <= '{default: '0};
            list_empty  <= '1;
            tail_bvalid <= 1'b0;
            page_wr_en  <= 1'b0;
        end else begin
            page_wr_en <= wr_accept && wr_word.wr.malloc_approved;
            if (wr_accept) begin
                tail_ptrs[tail_awaddr] <= wr_word.wr.new_tail_ptr;
                tail_bvalid <= 1'b1;
                if (wr_word.wr.malloc_approved) begin
                    // First page stays in slot 0, later pages move the slot on
                    if (list_empty[tail_awaddr]) begin
                        list_empty[tail_awaddr] <= 1'b0;
                    end else begin
                        wr_slot[tail_awaddr] <= wr_slot_p1;
                    end
                end
            end else if (tail_bready) begin
                tail_bvalid <= 1'b0;
            end
        end
    end

    // Memory write lands one cycle after the channel write
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (wr_accept) begin
            page_wr_data <= wr_word.wr.next_page_ptr;
            if (list_empty[tail_awaddr]) begin
                page_wr_addr <= {tail_awaddr, wr_slot[tail_awaddr]};
            end else begin
                page_wr_addr <= {tail_awaddr, wr_slot_p1};
            end
        end
    end

    //////////////////////////////////////////////////
    // Tail read

    assign tail_rd_addr = {tail_araddr, wr_slot[tail_araddr]};

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            tail_rvalid <= 1'b0;
        end else if (tail_arvalid) begin
            tail_rvalid <= 1'b1;
        end else if (tail_rready) begin
            tail_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail_arvalid) begin
            tail_ptr_rd   <= tail_ptrs[tail_araddr];
            page_valid_rd <= ~list_empty[tail_araddr];
        end
    end

    always_comb begin
        rd_word.rd.current_page_valid = page_valid_rd;
        rd_word.rd.current_page_ptr   = tail_rd_page;
        rd_word.rd.tail_ptr           = tail_ptr_rd;
    end

    assign tail_rdata = rd_word;

endmodule

`default_nettype wire

//--- queue_head_pointers.sv
/* Queue head pointer lookup */

`timescale 1ns/100ps
`default_nettype none

module queue_head_pointers
    import queue_states_pkg::*;
(
    input  wire logic                        enqueue_queue_occupancy_a4l,
    input  wire logic                        reset,

    input  wire logic                        head_arvalid,
    input  wire logic [QUEUE_W-1:0]          head_araddr,
    input  wire logic                        head_rready,
    output var  logic                        head_rvalid,
    output var  logic [HEAD_WORD_W-1:0]      head_rdata,

    // Second read port of the page memory
    output var  logic [PAGE_LIST_ADDR_W-1:0] head_rd_addr,
    input  wire logic [PAGE_W-1:0]           head_rd_page
);

    logic [WORD_W-1:0] head_ptrs [NUM_QUEUES];
    logic [PAGE_W-1:0] rd_slot   [NUM_QUEUES];

    logic              lookup_s0;
    logic [WORD_W-1:0] head_ptr_s0;
    logic [WORD_W-1:0] head_ptr_s1;

    assign head_rd_addr = {head_araddr, rd_slot[head_araddr]};

    //////////////////////////////////////////////////
    // Stage 0, pointer capture and advance

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            head_ptrs <= '{default: '0};
            rd_slot   <= '{default: '0};
            lookup_s0 <= 1'b0;
        end else begin
            lookup_s0 <= head_arvalid;
            if (head_arvalid) begin
                head_ptrs[head_araddr] <= head_ptrs[head_araddr] + 1'b1;
                // Last word of the page, move on to the next page in the list
                if (head_ptrs[head_araddr] == WORD_W'(WORDS_PER_PAGE - 1)) begin
                    rd_slot[head_araddr] <= rd_slot[head_araddr] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (head_arvalid) begin
            head_ptr_s0 <= head_ptrs[head_araddr];
        end
    end

    //////////////////////////////////////////////////
    // Stage 1, lines up with the second memory stage

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (lookup_s0) begin
            head_ptr_s1 <= head_ptr_s0;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            head_rvalid <= 1'b0;
        end else if (lookup_s0) begin
            head_rvalid <= 1'b1;
        end else if (head_rready) begin
            head_rvalid <= 1'b0;
        end
    end

    assign head_rdata = {head_ptr_s1, head_rd_page};

endmodule

`default_nettype wire

//--- page_pointer_ram.sv
/* Page list memory */

`timescale 1ns/100ps
`default_nettype none

module page_pointer_ram
    import queue_states_pkg::*;
(
    input  wire logic                        enqueue_queue_occupancy_a4l,

    input  wire logic                        wr_en,
    input  wire logic [PAGE_LIST_ADDR_W-1:0] wr_addr,
    input  wire logic [PAGE_W-1:0]           wr_data,

    // Tail side, one registered stage
    input  wire logic [PAGE_LIST_ADDR_W-1:0] rd_a_addr,
    output var  logic [PAGE_W-1:0]           rd_a_data,

    // Head side, two registered stages
    input  wire logic [PAGE_LIST_ADDR_W-1:0] rd_b_addr,
    output var  logic [PAGE_W-1:0]           rd_b_data
);

    logic [PAGE_W-1:0] mem [PAGE_LIST_DEPTH] = '{default: '0};
    logic [PAGE_W-1:0] rd_b_stage;

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_a_data  <= mem[rd_a_addr];
        rd_b_stage <= mem[rd_b_addr];
        rd_b_data  <= rd_b_stage;
    end

endmodule

`default_nettype wire

//--- queue_states_top.sv
/* Queue state store */

`timescale 1ns/100ps
`default_nettype none

module queue_states_top
    import queue_states_pkg::*;
(
    input  wire logic                   enqueue_queue_occupancy_a4l,
    input  wire logic                   reset,

    // Occupancy channel
    input  wire logic                   occ_awvalid,
    input  wire logic                   occ_wvalid,
    input  wire logic [QUEUE_W-1:0]     occ_awaddr,
    input  wire logic [OCC_W-1:0]       occ_wdata,
    input  wire logic                   occ_bready,
    output wire logic                   occ_bvalid,
    input  wire logic                   occ_arvalid,
    input  wire logic [QUEUE_W-1:0]     occ_araddr,
    input  wire logic                   occ_rready,
    output wire logic                   occ_rvalid,
    output wire logic [OCC_W-1:0]       occ_rdata,

    // Dequeue stream
    input  wire logic                   deq_tvalid,
    input  wire logic [OCC_W-1:0]       deq_tdata,
    input  wire logic [QUEUE_W-1:0]     deq_tuser,

    // Tail pointer channel
    input  wire logic                   tail_awvalid,
    input  wire logic                   tail_wvalid,
    input  wire logic [QUEUE_W-1:0]     tail_awaddr,
    input  wire logic [TAIL_WORD_W-1:0] tail_wdata,
    input  wire logic                   tail_bready,
    output wire logic                   tail_bvalid,
    input  wire logic                   tail_arvalid,
    input  wire logic [QUEUE_W-1:0]     tail_araddr,
    input  wire logic                   tail_rready,
    output wire logic                   tail_rvalid,
    output wire logic [TAIL_WORD_W-1:0] tail_rdata,

    // Head pointer lookup channel
    input  wire logic                   head_arvalid,
    input  wire logic [QUEUE_W-1:0]     head_araddr,
    input  wire logic                   head_rready,
    output wire logic                   head_rvalid,
    output wire logic [HEAD_WORD_W-1:0] head_rdata,

    output wire logic [NUM_QUEUES-1:0]  queue_empty
);

    wire logic                        page_wr_en;
    wire logic [PAGE_LIST_ADDR_W-1:0] page_wr_addr;
    wire logic [PAGE_W-1:0]           page_wr_data;
    wire logic [PAGE_LIST_ADDR_W-1:0] tail_rd_addr;
    wire logic [PAGE_W-1:0]           tail_rd_page;
    wire logic [PAGE_LIST_ADDR_W-1:0] head_rd_addr;
    wire logic [PAGE_W-1:0]           head_rd_page;

    queue_occupancy u_queue_occupancy (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .reset       (reset),
        .occ_awvalid (occ_awvalid),
        .occ_wvalid  (occ_wvalid),
        .occ_awaddr  (occ_awaddr),
        .occ_wdata   (occ_wdata),
        .occ_bready  (occ_bready),
        .occ_bvalid  (occ_bvalid),
        .occ_arvalid (occ_arvalid),
        .occ_araddr  (occ_araddr),
        .occ_rready  (occ_rready),
        .occ_rvalid  (occ_rvalid),
        .occ_rdata   (occ_rdata),
        .deq_tvalid  (deq_tvalid),
        .deq_tdata   (deq_tdata),
        .deq_tuser   (deq_tuser),
        .queue_empty (queue_empty)
    );

    queue_tail_pointers u_queue_tail_pointers (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .reset        (reset),
        .tail_awvalid (tail_awvalid),
        .tail_wvalid  (tail_wvalid),
        .tail_awaddr  (tail_awaddr),
        .tail_wdata   (tail_wdata),
        .tail_bready  (tail_bready),
        .tail_bvalid  (tail_bvalid),
        .tail_arvalid (tail_arvalid),
        .tail_araddr  (tail_araddr),
        .tail_rready  (tail_rready),
        .tail_rvalid  (tail_rvalid),
        .tail_rdata   (tail_rdata),
        .page_wr_en   (page_wr_en),
        .page_wr_addr (page_wr_addr),
        .page_wr_data (page_wr_data),
        .tail_rd_addr (tail_rd_addr),
        .tail_rd_page (tail_rd_page)
    );

    queue_head_pointers u_queue_head_pointers (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .reset        (reset),
        .head_arvalid (head_arvalid),
        .head_araddr  (head_araddr),
        .head_rready  (head_rready),
        .head_rvalid  (head_rvalid),
        .head_rdata   (head_rdata),
        .head_rd_addr (head_rd_addr),
        .head_rd_page (head_rd_page)
    );

    page_pointer_ram u_page_pointer_ram (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .wr_en     (page_wr_en),
        .wr_addr   (page_wr_addr),
        .wr_data   (page_wr_data),
        .rd_a_addr (tail_rd_addr),
        .rd_a_data (tail_rd_page),
        .rd_b_addr (head_rd_addr),
        .rd_b_data (head_rd_page)
    );

endmodule

`default_nettype wire

//--- queue_states_asserts.sv
/* Occupancy channel assertions */

`timescale 1ns/100ps
`default_nettype none

module queue_states_asserts
    import queue_states_pkg::*;
(
    input  wire logic             enqueue_queue_occupancy_a4l,
    input  wire logic             reset,
    input  wire logic             occ_awvalid,
    input  wire logic             occ_wvalid,
    input  wire logic             occ_bvalid,
    input  wire logic             occ_arvalid,
    input  wire logic             occ_rready,
    input  wire logic             occ_rvalid,
    input  wire logic [OCC_W-1:0] occ_rdata
);

    int assert_errors = 0;

    // One bvalid cycle per accepted write
    write_resp_follows: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) (occ_awvalid && occ_wvalid) |=> occ_bvalid)
        else begin
            assert_errors++;
            $error("occ_bvalid missing after an accepted write");
        end

    write_resp_pulse: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) !(occ_awvalid && occ_wvalid) |=> !occ_bvalid)
        else begin
            assert_errors++;
            $error("occ_bvalid high without an accepted write");
        end

    read_resp_held: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) (occ_rvalid && !occ_rready) |=> (occ_rvalid && $stable(occ_rdata)))
        else begin
            assert_errors++;
            $error("held occupancy response dropped or changed");
        end

    no_read_while_held: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) (occ_rvalid && !occ_rready) |-> !occ_arvalid)
        else begin
            assert_errors++;
            $error("occ_arvalid while a response is held");
        end

endmodule

bind queue_occupancy queue_states_asserts u_queue_states_asserts (.*);

`default_nettype wire

//--- queue_states_checker.sv
/* Queue state response checker */

`timescale 1ns/100ps
`default_nettype none

module queue_states_checker
    import queue_states_pkg::*;
(
    input  wire logic                   enqueue_queue_occupancy_a4l,
    input  wire logic                   reset,
    input  wire logic                   occ_awvalid,
    input  wire logic                   occ_wvalid,
    input  wire logic [QUEUE_W-1:0]     occ_awaddr,
    input  wire logic [OCC_W-1:0]       occ_wdata,
    input  wire logic                   occ_rvalid,
    input  wire logic                   occ_rready,
    input  wire logic [OCC_W-1:0]       occ_rdata,
    input  wire logic                   deq_tvalid,
    input  wire logic [OCC_W-1:0]       deq_tdata,
    input  wire logic [QUEUE_W-1:0]     deq_tuser,
    input  wire logic                   tail_rvalid,
    input  wire logic                   tail_rready,
    input  wire logic [TAIL_WORD_W-1:0] tail_rdata,
    input  wire logic                   head_rvalid,
    input  wire logic                   head_rready,
    input  wire logic [HEAD_WORD_W-1:0] head_rdata,
    input  wire logic [NUM_QUEUES-1:0]  queue_empty,
    input  wire logic [OCC_W-1:0]       exp_data,
    output var  int                     error_count,
    output var  int                     check_count
);

    // Occupancy mirror built from the observed traffic
    logic [OCC_W-1:0]   occ_model [NUM_QUEUES];
    logic [OCC_W-1:0]   step_occ;
    logic               collide;
    logic               pend_valid;
    logic [QUEUE_W-1:0] pend_queue;
    logic [OCC_W-1:0]   pend_bytes;
    logic               held_valid;
    logic [OCC_W-1:0]   held_data;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare(input string what, input logic [OCC_W-1:0] got);
        check_count++;
        if (got !== exp_data) begin
            error_count++;
            $display("error at %0t: %s read returned 'h%0h, expected 'h%0h",
                     $time, what, got, exp_data);
        end
    endtask

    always @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            occ_model  <= '{default: '0};
            pend_valid <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (queue_empty[q] !== (occ_model[q] == '0)) begin
                    error_count++;
                    $display("error at %0t: queue_empty[%0d] is %b, model occupancy %0d",
                             $time, q, queue_empty[q], occ_model[q]);
                end
            end
            if (occ_rvalid && occ_rready) compare("occupancy", occ_rdata);
            if (tail_rvalid && tail_rready) compare("tail", OCC_W'(tail_rdata));
            if (head_rvalid && head_rready) compare("head", OCC_W'(head_rdata));
            // Parked response must not drop or change
            if (held_valid && (!occ_rvalid || occ_rdata !== held_data)) begin
                error_count++;
                $display("error at %0t: held occupancy response changed", $time);
            end
            held_valid <= occ_rvalid && !occ_rready;
            held_data  <= occ_rdata;

            // Same-queue enqueue waits one cycle behind the dequeue
            collide = occ_awvalid && occ_wvalid && deq_tvalid && occ_awaddr == deq_tuser;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                step_occ = occ_model[q];
                if (pend_valid && pend_queue == QUEUE_W'(q)) step_occ += pend_bytes;
                if (occ_awvalid && occ_wvalid && !collide && occ_awaddr == QUEUE_W'(q)) begin
                    step_occ += occ_wdata;
                end
                if (deq_tvalid && deq_tuser == QUEUE_W'(q)) step_occ -= deq_tdata;
                occ_model[q] <= step_occ;
            end
            pend_valid <= collide;
            pend_queue <= occ_awaddr;
            pend_bytes <= occ_wdata;
        end
    end

endmodule

`default_nettype wire

//--- tb_queue_states.sv
/* Queue state store testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_queue_states
    import queue_states_pkg::*;
();

    localparam int OP_ENQ      = 0;
    localparam int OP_DEQ      = 1;
    localparam int OP_COLL     = 2;
    localparam int OP_TAIL_WR  = 3;
    localparam int OP_TAIL_RD  = 4;
    localparam int OP_HEAD_RD  = 5;
    localparam int OP_OCC_RD   = 6;
    localparam int OP_OCC_HOLD = 7;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int HOLD_CYCLES    = 4;
    localparam int COLL_DEQ_BYTES = 24;
    localparam int FIRST_PAGE     = 'ha;
    localparam int SECOND_PAGE    = 'h6;

    logic                   enqueue_queue_occupancy_a4l;
    logic                   reset;
    logic                   occ_awvalid;
    logic                   occ_wvalid;
    logic [QUEUE_W-1:0]     occ_awaddr;
    logic [OCC_W-1:0]       occ_wdata;
    logic                   occ_bready;
    logic                   occ_bvalid;
    logic                   occ_arvalid;
    logic [QUEUE_W-1:0]     occ_araddr;
    logic                   occ_rready;
    logic                   occ_rvalid;
    logic [OCC_W-1:0]       occ_rdata;
    logic                   deq_tvalid;
    logic [OCC_W-1:0]       deq_tdata;
    logic [QUEUE_W-1:0]     deq_tuser;
    logic                   tail_awvalid;
    logic                   tail_wvalid;
    logic [QUEUE_W-1:0]     tail_awaddr;
    logic [TAIL_WORD_W-1:0] tail_wdata;
    logic                   tail_bready;
    logic                   tail_bvalid;
    logic                   tail_arvalid;
    logic [QUEUE_W-1:0]     tail_araddr;
    logic                   tail_rready;
    logic                   tail_rvalid;
    logic [TAIL_WORD_W-1:0] tail_rdata;
    logic                   head_arvalid;
    logic [QUEUE_W-1:0]     head_araddr;
    logic                   head_rready;
    logic                   head_rvalid;
    logic [HEAD_WORD_W-1:0] head_rdata;
    logic [NUM_QUEUES-1:0]  queue_empty;

    // Expected read data handed to the checker
    logic [OCC_W-1:0]       exp_data;
    int                     error_count;
    int                     check_count;

    // Stimulus table with one entry per row in each queue
    int row_op    [$];
    int row_queue [$];
    int row_data  [$];
    int row_exp   [$];

    int     occ_mirror [NUM_QUEUES];
    int     tail_valid;
    int     tail_page;
    int     tail_ptr;
    int     num_reads;
    int     timeouts;
    int     assert_fails;
    integer seed = 32'he716;

    queue_states_top u_queue_states_top (.*);

    queue_states_checker u_queue_states_checker (.*);

    initial begin
        enqueue_queue_occupancy_a4l = 1'b0;
        forever #10 enqueue_queue_occupancy_a4l = ~enqueue_queue_occupancy_a4l;
    end

    //////////////////////////////////////////////////
    // Table construction

    task automatic add_row(input int op, input int q, input int data, input int exp);
        row_op.push_back(op);
        row_queue.push_back(q);
        row_data.push_back(data);
        row_exp.push_back(exp);
        if (op == OP_TAIL_RD || op == OP_HEAD_RD || op == OP_OCC_RD || op == OP_OCC_HOLD) begin
            num_reads++;
        end
    endtask

    task automatic add_enqueue(input int q, input int op);
        int bytes;
        bytes = 32 + ($random(seed) & 127);
        occ_mirror[q] += bytes;
        if (op == OP_COLL) begin
            occ_mirror[q] -= COLL_DEQ_BYTES;
        end
        add_row(op, q, bytes, 0);
    endtask

    task automatic add_tail_write(input int q, input int malloc, input int page, input int ptr);
        tail_ptr = ptr;
        if (malloc != 0) begin
            tail_valid = 1;
            tail_page  = page;
        end
        add_row(OP_TAIL_WR, q, (malloc << (PAGE_W + WORD_W)) | (page << WORD_W) | ptr, 0);
    endtask

    task automatic add_tail_read(input int q);
        add_row(OP_TAIL_RD, q, 0,
                (tail_valid << (PAGE_W + WORD_W)) | (tail_page << WORD_W) | tail_ptr);
    endtask

    task automatic build_table();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            add_row(OP_OCC_RD, q, 0, 0);
        end
        add_row(OP_TAIL_RD, 0, 0, 0);
        for (int n = 0; n < 2; n++) begin
            for (int q = 1; q <= 3; q++) begin
                add_enqueue(q, OP_ENQ);
            end
        end
        for (int q = 1; q <= 3; q++) begin
            add_row(OP_OCC_RD, q, 0, occ_mirror[q]);
        end
        // Queue 1 drains to empty and queue 2 to half
        add_row(OP_DEQ, 1, occ_mirror[1], 0);
        occ_mirror[1] = 0;
        add_row(OP_DEQ, 2, occ_mirror[2] / 2, 0);
        occ_mirror[2] -= occ_mirror[2] / 2;
        add_row(OP_OCC_RD, 1, 0, occ_mirror[1]);
        add_row(OP_OCC_RD, 2, 0, occ_mirror[2]);
        add_enqueue(3, OP_COLL);
        add_row(OP_OCC_RD, 3, 0, occ_mirror[3]);
        add_tail_write(5, 1, FIRST_PAGE, 3);
        add_tail_read(5);
        add_tail_write(5, 0, 'hf, 5);
        add_tail_read(5);
        add_tail_write(5, 1, SECOND_PAGE, 2);
        add_tail_read(5);
        // Head word is {word pointer, page}
        for (int n = 0; n < 10; n++) begin
            add_row(OP_HEAD_RD, 5, 0, ((n % WORDS_PER_PAGE) << PAGE_W)
                    | (n < WORDS_PER_PAGE ? FIRST_PAGE : SECOND_PAGE));
        end
        add_row(OP_OCC_HOLD, 2, 0, occ_mirror[2]);
        add_row(OP_OCC_RD, 7, 0, 0);
    endtask

    function automatic logic response_flag(input int op);
        case (op)
            OP_ENQ, OP_COLL: return occ_bvalid;
            OP_TAIL_WR:      return tail_bvalid;
            OP_TAIL_RD:      return tail_rvalid;
            OP_HEAD_RD:      return head_rvalid;
            default:         return occ_rvalid;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Driving loop

    initial begin
        int op;
        int waited;
        reset = 1'b1;
        {occ_awvalid, occ_wvalid, occ_arvalid, deq_tvalid} = '0;
        {tail_awvalid, tail_wvalid, tail_arvalid, head_arvalid} = '0;
        occ_awaddr  = '0;
        occ_wdata   = '0;
        occ_araddr  = '0;
        deq_tdata   = '0;
        deq_tuser   = '0;
        tail_awaddr = '0;
        tail_wdata  = '0;
        tail_araddr = '0;
        head_araddr = '0;
        {occ_bready, occ_rready, tail_bready, tail_rready, head_rready} = '1;
        exp_data   = '0;
        occ_mirror = '{default: 0};
        {tail_valid, tail_page, tail_ptr, num_reads, timeouts} = '0;
        build_table();

        repeat (2) @(posedge enqueue_queue_occupancy_a4l);
        @(negedge enqueue_queue_occupancy_a4l);
        reset = 1'b0;
        @(negedge enqueue_queue_occupancy_a4l);

        for (int i = 0; i < row_op.size(); i++) begin
            op = row_op[i];
            exp_data = OCC_W'(row_exp[i]);
            case (op)
                OP_ENQ, OP_COLL: begin
                    occ_awvalid = 1'b1;
                    occ_wvalid  = 1'b1;
                    occ_awaddr  = QUEUE_W'(row_queue[i]);
                    occ_wdata   = OCC_W'(row_data[i]);
                    if (op == OP_COLL) begin
                        deq_tvalid = 1'b1;
                        deq_tuser  = QUEUE_W'(row_queue[i]);
                        deq_tdata  = OCC_W'(COLL_DEQ_BYTES);
                    end
                end
                OP_DEQ: begin
                    deq_tvalid = 1'b1;
                    deq_tuser  = QUEUE_W'(row_queue[i]);
                    deq_tdata  = OCC_W'(row_data[i]);
                end
                OP_TAIL_WR: begin
                    tail_awvalid = 1'b1;
                    tail_wvalid  = 1'b1;
                    tail_awaddr  = QUEUE_W'(row_queue[i]);
                    tail_wdata   = TAIL_WORD_W'(row_data[i]);
                end
                OP_TAIL_RD: begin
                    tail_arvalid = 1'b1;
                    tail_araddr  = QUEUE_W'(row_queue[i]);
                end
                OP_HEAD_RD: begin
                    head_arvalid = 1'b1;
                    head_araddr  = QUEUE_W'(row_queue[i]);
                end
                default: begin
                    occ_arvalid = 1'b1;
                    occ_araddr  = QUEUE_W'(row_queue[i]);
                    occ_rready  = (op == OP_OCC_RD);
                end
            endcase
            @(negedge enqueue_queue_occupancy_a4l);
            {occ_awvalid, occ_wvalid, occ_arvalid, deq_tvalid} = '0;
            {tail_awvalid, tail_wvalid, tail_arvalid, head_arvalid} = '0;

            if (op != OP_DEQ) begin
                waited = 0;
                while (!response_flag(op) && waited < TIMEOUT_CYCLES) begin
                    @(negedge enqueue_queue_occupancy_a4l);
                    waited++;
                end
                if (!response_flag(op)) begin
                    timeouts++;
                    $display("timeout at %0t, no response to table row %0d", $time, i);
                end else if (op == OP_OCC_HOLD) begin
                    // Response stays parked while rready is low
                    repeat (HOLD_CYCLES) @(negedge enqueue_queue_occupancy_a4l);
                    occ_rready = 1'b1;
                end
            end
            // Keeps reads clear of the preceding write
            repeat (3) @(negedge enqueue_queue_occupancy_a4l);
        end

        assert_fails = u_queue_states_top.u_queue_occupancy.u_queue_states_asserts.assert_errors;
        if (check_count != num_reads) begin
            $display("some read responses never reached the checker");
        end
        $display("checked %0d of %0d reads, %0d errors, %0d timeouts, %0d assertion failures",
                 check_count, num_reads, error_count, timeouts, assert_fails);
        if (error_count == 0 && timeouts == 0 && assert_fails == 0
                && check_count == num_reads) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- queue_states.f
queue_states_pkg.sv
queue_occupancy.sv
queue_tail_pointers.sv
queue_head_pointers.sv
page_pointer_ram.sv
queue_states_top.sv
queue_states_asserts.sv
queue_states_checker.sv
tb_queue_states.sv
